/* logic/cache_pkg.sv */
/*
 * Shared widths, command encoding and packet types for the cache request path.
 * Imported by every RTL module of the subsystem.
 */
`default_nettype none

package cache_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int ADDR_W      = 32;
  localparam int INDEX_W     = 16;
  localparam int COUNT_W     = 16;
  localparam int ENGINE_ID_W = 4;
  // Elements are 4-byte words
  localparam int WORD_SHIFT  = 2;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [INDEX_W-1:0]     index_t;
  typedef logic [COUNT_W-1:0]     count_t;
  typedef logic [ENGINE_ID_W-1:0] engine_id_t;

  // Packet command, CMD_ENGINE marks the end of an engine's walk
  typedef enum logic [1:0] {
    CMD_INVALID      = 2'd0,
    CMD_READ         = 2'd1,
    CMD_ENGINE       = 2'd2,
    CMD_MEM_RESPONSE = 2'd3
  } cmd_e;

  // ------------------------------------------------------------
  // Structs
  // ------------------------------------------------------------
  // Kernel descriptor, 49 bits
  typedef struct packed {
    logic   valid;
    addr_t  base;
    count_t count;
  } kernel_descriptor_t;

  // Engine request packet, 23 bits
  typedef struct packed {
    logic       valid;
    engine_id_t id;
    cmd_e       cmd;
    index_t     index;
  } engine_packet_t;

  // Cache request, 39 bits
  typedef struct packed {
    logic       valid;
    engine_id_t id;
    cmd_e       cmd;
    addr_t      address;
  } cache_request_t;

  // Element index to byte address, other fields pass through
  function automatic cache_request_t map_engine_to_cache_request(
    input engine_packet_t     packet,
    input kernel_descriptor_t descriptor
  );
    cache_request_t request;
    request.valid   = packet.valid;
    request.id      = packet.id;
    request.cmd     = packet.cmd;
    request.address = descriptor.base + (addr_t'(packet.index) << WORD_SHIFT);
    return request;
  endfunction

endpackage

`default_nettype wire

/* logic/kernel_setup.sv */
/*
 * Holds the active kernel descriptor and broadcasts it to the engines.
 * Pulses start once per descriptor and folds the engine done flags into one.
 */
`timescale 1ns/100ps
`default_nettype none

module kernel_setup
  import cache_pkg::*;
#(
  parameter int NUM_ENGINES = 4
) (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  input  kernel_descriptor_t     descriptor_in,
  input  logic [NUM_ENGINES-1:0] engine_done,
  output kernel_descriptor_t     descriptor_out,
  output logic                   start,
  output logic                   kernel_done
);

  // Descriptor captured, start goes out next cycle
  logic loaded_q;

  // ------------------------------------------------------------
  // Descriptor register and start pulse
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      descriptor_out.valid <= 1'b0;
      loaded_q             <= 1'b0;
      start                <= 1'b0;
    end else begin
      if (descriptor_in.valid) begin
        descriptor_out <= descriptor_in;
      end
      loaded_q <= descriptor_in.valid;
      start    <= loaded_q;
    end
  end

  // ------------------------------------------------------------
  // Kernel done
  // ------------------------------------------------------------
  // Old done flags linger until the engines see start
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      kernel_done <= 1'b0;
    end else if (descriptor_in.valid) begin
      kernel_done <= 1'b0;
    end else if (descriptor_out.valid && !loaded_q && !start && (&engine_done)) begin
      kernel_done <= 1'b1;
    end
  end

  // Start is a single-cycle pulse per descriptor
  assert property (@(posedge ap_clk) disable iff (areset_control) start |=> !start);

endmodule

`default_nettype wire

/* logic/address_engine.sv */
/*
 * Walks one engine's share of element indices and offers each as a read.
 * Ends every walk with a single completion marker, then reports done.
 */
`timescale 1ns/100ps
`default_nettype none

module address_engine
  import cache_pkg::*;
#(
  parameter int NUM_ENGINES = 4,
  parameter int ENGINE_ID   = 0
) (
  input  logic               ap_clk,
  input  logic               areset_control,
  input  kernel_descriptor_t descriptor,
  input  logic               start,
  input  logic               grant,
  output logic               request,
  output engine_packet_t     packet,
  output logic               done
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    MARK,
    DONE
  } state_e;

  localparam index_t FIRST_INDEX = index_t'(ENGINE_ID);

  state_e             state_q;
  index_t             index_q;
  // One extra bit so the stride cannot wrap past the count
  logic [INDEX_W:0]   next_index;
  logic               pending;

  assign next_index = {1'b0, index_q} + (INDEX_W+1)'(NUM_ENGINES);
  assign pending    = (state_q == ISSUE) || (state_q == MARK);

  // ------------------------------------------------------------
  // Index walker
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= IDLE;
    end else if (start) begin
      // Restart from own first index on every descriptor
      index_q <= FIRST_INDEX;
      state_q <= (FIRST_INDEX < descriptor.count) ? ISSUE : MARK;
    end else begin
      case (state_q)
        ISSUE: begin
          if (grant) begin
            index_q <= next_index[INDEX_W-1:0];
            if (next_index < {1'b0, descriptor.count}) begin
              state_q <= ISSUE;
            end else begin
              state_q <= MARK;
            end
          end
        end
        MARK: begin
          if (grant) begin
            state_q <= DONE;
          end
        end
        default: begin
          state_q <= state_q;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Request and packet
  // ------------------------------------------------------------
  // Dropped while granted so the registered copy goes stale at once
  assign request = pending && !grant;
  assign done    = (state_q == DONE);

  always_comb begin
    packet.valid = request;
    packet.id    = engine_id_t'(ENGINE_ID);
    packet.cmd   = (state_q == ISSUE) ? CMD_READ : CMD_ENGINE;
    packet.index = index_q;
  end

  // Offered item is held until the arbiter answers
  assert property (@(posedge ap_clk) disable iff (areset_control)
    (request && !grant && !start) |=> (grant || $stable(packet)));

endmodule

`default_nettype wire

/* logic/round_robin_arbiter.sv */
/*
 * Rotating-priority arbiter over the registered engine requests.
 * Registers one grant and the winning packet per cycle; hold stalls it.
 */
`timescale 1ns/100ps
`default_nettype none

module round_robin_arbiter
  import cache_pkg::*;
#(
  parameter int NUM_ENGINES = 4
) (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  input  logic [NUM_ENGINES-1:0] request,
  input  logic [NUM_ENGINES-1:0] bus_valid,
  input  engine_packet_t         bus_in [NUM_ENGINES],
  input  logic                   hold,
  output logic [NUM_ENGINES-1:0] grant,
  output engine_packet_t         bus_out
);

  localparam int SEL_W = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;

  logic [SEL_W-1:0]       last_q;
  logic [SEL_W-1:0]       winner;
  logic                   found;
  logic [NUM_ENGINES-1:0] grant_d;
  logic [NUM_ENGINES-1:0] eligible;
  logic [NUM_ENGINES-1:0] grant_next;

  // Mask covers the grant round trip back to the engine
  assign eligible = request & bus_valid & ~grant & ~grant_d & {NUM_ENGINES{!hold}};

  // ------------------------------------------------------------
  // Pick first eligible after last winner
  // ------------------------------------------------------------
  always_comb begin
    int unsigned cand;
    grant_next = '0;
    winner     = last_q;
    found      = 1'b0;
    for (int off = 1; off <= NUM_ENGINES; off++) begin
      cand = int'(last_q) + off;
      if (cand >= NUM_ENGINES) begin
        cand = cand - NUM_ENGINES;
      end
      if (!found && eligible[cand]) begin
        found            = 1'b1;
        winner           = SEL_W'(cand);
        grant_next[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant         <= '0;
      grant_d       <= '0;
      bus_out.valid <= 1'b0;
      // Engine 0 has priority first
      last_q        <= SEL_W'(NUM_ENGINES - 1);
    end else begin
      grant         <= grant_next;
      grant_d       <= grant;
      bus_out       <= bus_in[winner];
      bus_out.valid <= found;
      if (found) begin
        last_q <= winner;
      end
    end
  end

  assert property (@(posedge ap_clk) disable iff (areset_control) $onehot0(grant));

endmodule

`default_nettype wire

/* logic/request_fifo.sv */
/*
 * Synchronous FIFO for cache requests with a registered read port.
 * Read data and valid appear one cycle after a read is accepted.
 */
`timescale 1ns/100ps
`default_nettype none

module request_fifo
  import cache_pkg::*;
#(
  parameter int DEPTH       = 32,
  parameter int PROG_THRESH = 16
) (
  input  logic           ap_clk,
  input  logic           areset_control,
  input  cache_request_t din,
  input  logic           wr_en,
  input  logic           rd_en,
  output cache_request_t dout,
  output logic           valid,
  output logic           full,
  output logic           empty,
  output logic           prog_full,
  output logic           setup
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  cache_request_t   mem [DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Status from occupancy
  assign full      = (count_q == CNT_W'(DEPTH));
  assign empty     = (count_q == '0);
  assign prog_full = (count_q >= CNT_W'(PROG_THRESH));

  // No traffic while coming out of reset
  assign push = wr_en && !full && !setup;
  assign pop  = rd_en && !empty && !setup;

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wptr_q] <= din;
    end
    if (pop) begin
      dout <= mem[rptr_q];
    end
  end

  // ------------------------------------------------------------
  // Pointers, count, flags
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
      valid   <= 1'b0;
      setup   <= 1'b1;
    end else begin
      setup <= 1'b0;
      valid <= pop;
      if (push) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Upstream must throttle before the buffer fills
  assert property (@(posedge ap_clk) disable iff (areset_control) !(wr_en && full));

endmodule

`default_nettype wire

/* logic/cache_request_generator.sv */
/*
 * Drains the address engines into one ordered cache request stream.
 * Inputs are registered, arbitrated, mapped to byte addresses and queued.
 */
`timescale 1ns/100ps
`default_nettype none

module cache_request_generator
  import cache_pkg::*;
#(
  parameter int NUM_ENGINES = 4,
  parameter int FIFO_DEPTH  = 32,
  parameter int PROG_THRESH = 16
) (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  input  kernel_descriptor_t     descriptor,
  input  logic [NUM_ENGINES-1:0] engine_request,
  input  engine_packet_t         engine_packet [NUM_ENGINES],
  output logic [NUM_ENGINES-1:0] engine_grant,
  input  logic                   rd_en,
  output cache_request_t         request_out,
  output logic                   fifo_setup
);

  // Input capture
  logic [NUM_ENGINES-1:0] request_q;
  engine_packet_t         packet_q [NUM_ENGINES];
  logic [NUM_ENGINES-1:0] packet_valid;
  logic                   rd_en_q;

  // Arbiter side
  logic [NUM_ENGINES-1:0] arb_grant;
  engine_packet_t         arb_bus_out;

  // FIFO side
  cache_request_t         mapped_q;
  cache_request_t         fifo_dout;
  logic                   fifo_wr_en;
  logic                   fifo_rd_en;
  logic                   fifo_valid;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic                   fifo_prog_full;
  logic                   fifo_setup_int;

  // ------------------------------------------------------------
  // Register inputs
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_q <= '0;
      rd_en_q   <= 1'b0;
      for (int i = 0; i < NUM_ENGINES; i++) begin
        packet_q[i].valid <= 1'b0;
      end
    end else begin
      request_q <= engine_request;
      rd_en_q   <= rd_en;
      for (int i = 0; i < NUM_ENGINES; i++) begin
        packet_q[i] <= engine_packet[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_ENGINES; i++) begin
      packet_valid[i] = packet_q[i].valid;
    end
  end

  // ------------------------------------------------------------
  // Arbitration
  // ------------------------------------------------------------
  // Stall all engines while the queue is near full
  round_robin_arbiter #(
    .NUM_ENGINES(NUM_ENGINES)
  ) u_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request       (request_q),
    .bus_valid     (packet_valid),
    .bus_in        (packet_q),
    .hold          (fifo_prog_full | fifo_full),
    .grant         (arb_grant),
    .bus_out       (arb_bus_out)
  );

  // ------------------------------------------------------------
  // Map and filter
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      mapped_q.valid <= 1'b0;
    end else begin
      mapped_q <= map_engine_to_cache_request(arb_bus_out, descriptor);
    end
  end

  // Only reads reach the cache, markers end here
  assign fifo_wr_en = mapped_q.valid && (mapped_q.cmd == CMD_READ);
  assign fifo_rd_en = rd_en_q && !fifo_empty;

  request_fifo #(
    .DEPTH      (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) u_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (mapped_q),
    .wr_en         (fifo_wr_en),
    .rd_en         (fifo_rd_en),
    .dout          (fifo_dout),
    .valid         (fifo_valid),
    .full          (fifo_full),
    .empty         (fifo_empty),
    .prog_full     (fifo_prog_full),
    .setup         (fifo_setup_int)
  );

  // ------------------------------------------------------------
  // Register outputs
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      engine_grant      <= '0;
      fifo_setup        <= 1'b1;
      request_out.valid <= 1'b0;
    end else begin
      engine_grant      <= arb_grant;
      fifo_setup        <= fifo_setup_int;
      request_out       <= fifo_dout;
      // Stored valid bit is stale, FIFO valid marks the pop
      request_out.valid <= fifo_valid;
    end
  end

endmodule

`default_nettype wire

/* logic/cache_request_top.sv */
/*
 * Top level of the cache request subsystem.
 * Kernel setup feeds NUM_ENGINES address engines, the generator drains them.
 */
`timescale 1ns/100ps
`default_nettype none

module cache_request_top
  import cache_pkg::*;
#(
  parameter int NUM_ENGINES = 4,
  parameter int FIFO_DEPTH  = 32,
  parameter int PROG_THRESH = 16
) (
  input  logic               ap_clk,
  input  logic               areset_control,
  input  kernel_descriptor_t descriptor_in,
  input  logic               rd_en,
  output cache_request_t     request_out,
  output logic               fifo_setup,
  output logic               kernel_done
);

  kernel_descriptor_t     descriptor;
  logic                   start;
  logic [NUM_ENGINES-1:0] engine_done;
  logic [NUM_ENGINES-1:0] engine_request;
  logic [NUM_ENGINES-1:0] engine_grant;
  engine_packet_t         engine_packet [NUM_ENGINES];

  // ------------------------------------------------------------
  // Descriptor and start
  // ------------------------------------------------------------
  kernel_setup #(
    .NUM_ENGINES(NUM_ENGINES)
  ) u_setup (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .descriptor_in (descriptor_in),
    .engine_done   (engine_done),
    .descriptor_out(descriptor),
    .start         (start),
    .kernel_done   (kernel_done)
  );

  // ------------------------------------------------------------
  // Address engines, interleaved over the index space
  // ------------------------------------------------------------
  for (genvar k = 0; k < NUM_ENGINES; k++) begin : g_engine
    address_engine #(
      .NUM_ENGINES(NUM_ENGINES),
      .ENGINE_ID  (k)
    ) u_engine (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .descriptor    (descriptor),
      .start         (start),
      .grant         (engine_grant[k]),
      .request       (engine_request[k]),
      .packet        (engine_packet[k]),
      .done          (engine_done[k])
    );
  end

  // Request generator and output queue
  cache_request_generator #(
    .NUM_ENGINES(NUM_ENGINES),
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) u_generator (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .descriptor    (descriptor),
    .engine_request(engine_request),
    .engine_packet (engine_packet),
    .engine_grant  (engine_grant),
    .rd_en         (rd_en),
    .request_out   (request_out),
    .fifo_setup    (fifo_setup)
  );

endmodule

`default_nettype wire

/* tb/cache_request_checker.sv */
/*
 * Watches the cache request output of the DUT and checks each delivered
 * request against the requests the testbench queued, in per-engine order.
 */
`timescale 1ns/100ps
`default_nettype none

module cache_request_checker
  import cache_pkg::*;
(
  input  logic           ap_clk,
  input  logic           areset_control,
  input  cache_request_t expected_in,
  input  cache_request_t request_out,
  output int             error_count,
  output int             received_count
);

  // Outstanding expected requests of all engines in arrival order
  cache_request_t pending_q [$];

  // ------------------------------------------------------------
  // Compare one delivered request
  // ------------------------------------------------------------
  task automatic compare_output(input cache_request_t actual);
    int             hit;
    cache_request_t want;
    hit = -1;
    // Oldest pending entry of the same engine
    for (int j = 0; j < pending_q.size(); j++) begin
      if (hit < 0 && pending_q[j].id == actual.id) begin
        hit = j;
      end
    end
    received_count++;
    if (actual.cmd != CMD_READ) begin
      // Leaked marker or junk leaves the queue untouched
      $display("Fail request_out.cmd expected %h got %h", CMD_READ, actual.cmd);
      error_count++;
    end else if (hit < 0) begin
      $display("Unexpected cache request from engine %0d at address %h",
               actual.id, actual.address);
      error_count++;
    end else begin
      want = pending_q[hit];
      pending_q.delete(hit);
      if (actual.address != want.address) begin
        $display("Fail request_out.address expected %h got %h",
                 want.address, actual.address);
        error_count++;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Sampling
  // ------------------------------------------------------------
  // Ports are read at the rising edge before the DUT updates land
  always @(posedge ap_clk) begin
    if (areset_control) begin
      error_count    = 0;
      received_count = 0;
    end else begin
      if (expected_in.valid) begin
        pending_q.push_back(expected_in);
      end
      if (request_out.valid) begin
        compare_output(request_out);
      end
    end
  end

endmodule

`default_nettype wire

/* tb/cache_request_tb.sv */
/*
 * Testbench for the cache request subsystem: clock, reset, descriptors,
 * random consumer strobes and the final report. The checker does the compares.
 */
`timescale 1ns/100ps
`default_nettype none

module cache_request_tb
  import cache_pkg::*;
();

  localparam int NUM_ENGINES = 4;
  localparam int FIFO_DEPTH  = 32;
  localparam int PROG_THRESH = 16;
  // Cycle limit for every wait loop
  localparam int WAIT_LIMIT  = 2000;

  logic               ap_clk;
  logic               areset_control;
  kernel_descriptor_t descriptor_in;
  logic               rd_en;
  cache_request_t     request_out;
  logic               fifo_setup;
  logic               kernel_done;
  cache_request_t     expected_in;
  int                 checker_errors;
  int                 received_count;
  int                 tb_errors;
  int                 expected_total;
  integer             seed;

  cache_request_top #(
    .NUM_ENGINES(NUM_ENGINES),
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) dut (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .descriptor_in (descriptor_in),
    .rd_en         (rd_en),
    .request_out   (request_out),
    .fifo_setup    (fifo_setup),
    .kernel_done   (kernel_done)
  );

  cache_request_checker u_checker (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .expected_in   (expected_in),
    .request_out   (request_out),
    .error_count   (checker_errors),
    .received_count(received_count)
  );

  // 4 ns period
  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // Byte address of an element in 4-byte words
  function automatic addr_t expected_address(input addr_t base, input int index);
    return base + addr_t'(index) * 32'd4;
  endfunction

  // ------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------
  // Engine k owns indices k, k+NUM_ENGINES, ...
  task automatic load_expected(input addr_t base, input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge ap_clk);
      expected_in.valid   = 1'b1;
      expected_in.id      = engine_id_t'(i % NUM_ENGINES);
      expected_in.cmd     = CMD_READ;
      expected_in.address = expected_address(base, i);
    end
    @(negedge ap_clk);
    expected_in.valid = 1'b0;
    expected_total += count;
  endtask

  task automatic run_kernel(input addr_t base, input int count, input bit full_rate);
    int cycles;
    load_expected(base, count);
    @(negedge ap_clk);
    descriptor_in.valid = 1'b1;
    descriptor_in.base  = base;
    descriptor_in.count = count_t'(count);
    @(negedge ap_clk);
    descriptor_in.valid = 1'b0;
    if (kernel_done) begin
      $display("Fail kernel_done expected %h got %h", 1'b0, kernel_done);
      tb_errors++;
    end
    // Drain with about 25% read duty unless at full rate
    cycles = 0;
    while (received_count < expected_total && cycles < WAIT_LIMIT) begin
      rd_en = full_rate ? 1'b1 : (($random(seed) & 3) == 0);
      @(negedge ap_clk);
      cycles++;
    end
    rd_en = 1'b0;
    if (received_count < expected_total) begin
      $display("Timed out waiting for cache requests, %0d of %0d delivered",
               received_count, expected_total);
      tb_errors++;
    end
    cycles = 0;
    while (!kernel_done && cycles < WAIT_LIMIT) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (!kernel_done) begin
      $display("Timed out waiting for kernel_done");
      tb_errors++;
    end
    // Quiet window where a late extra output shows as a count mismatch
    repeat (20) @(negedge ap_clk);
    if (received_count != expected_total) begin
      $display("Fail received_count expected %h got %h", expected_total, received_count);
      tb_errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int cycles;
    seed           = 32'h7411;
    areset_control = 1'b1;
    descriptor_in  = '0;
    rd_en          = 1'b0;
    expected_in    = '0;
    tb_errors      = 0;
    expected_total = 0;
    repeat (3) @(negedge ap_clk);
    areset_control = 1'b0;

    // FIFO leaves setup while outputs stay quiet
    cycles = 0;
    while (fifo_setup && cycles < 20) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (fifo_setup) begin
      $display("fifo_setup stayed high after reset");
      tb_errors++;
    end
    repeat (10) begin
      @(negedge ap_clk);
      if (request_out.valid) begin
        $display("Fail request_out.valid expected %h got %h", 1'b0, request_out.valid);
        tb_errors++;
      end
      if (kernel_done) begin
        $display("Fail kernel_done expected %h got %h", 1'b0, kernel_done);
        tb_errors++;
      end
    end

    run_kernel(32'h0000_1000, 10, 1'b1);
    // Enough elements to push the FIFO past its threshold
    run_kernel(32'h0000_1000, 40, 1'b0);
    // Fewer elements than engines so one engine only sends its marker
    run_kernel(32'h8000_0400, 3, 1'b0);

    $display("Errors: checker %0d, testbench %0d; outputs %0d of %0d",
             checker_errors, tb_errors, received_count, expected_total);
    if (checker_errors == 0 && tb_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
logic/cache_pkg.sv
logic/kernel_setup.sv
logic/address_engine.sv
logic/round_robin_arbiter.sv
logic/request_fifo.sv
logic/cache_request_generator.sv
logic/cache_request_top.sv
tb/cache_request_checker.sv
tb/cache_request_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache request testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module cache_request_tb \
  --Mdir obj_dir -o cache_request_sim

out=$(./obj_dir/cache_request_sim)
echo "$out"
echo "$out" | grep -q "All tests passed!"
